/* build.f */
+incdir+include
design/ex_pkg.sv
design/ex_issue_router.sv
design/ex_int_lane.sv
design/ex_mult_lane.sv
design/ex_complete_queue.sv
design/ex_stage.sv
sim/ex_stage_tb.sv

/* Makefile */
SIM      := verilator
TOP      := ex_stage_tb
FILELIST := build.f
FLAGS    := --binary --timing --assert -Wno-fatal -Iinclude
OBJ_DIR  := obj_dir
BIN      := $(OBJ_DIR)/V$(TOP)
LOG      := sim.log

SOURCES  := $(shell grep -v '^+' $(FILELIST)) $(wildcard include/*.svh)

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)

# the log decides pass or fail, so the run status of the binary is not needed
run: $(BIN)
	-./$(BIN) 2>&1 | tee $(LOG)
	@grep -q "TEST RESULT: PASS" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* sim/ex_patterns.hex */
// ctl(kind valid unit alu mfunc opa opb cond/uncond) inst pc npc rs1 rs2 tag
// exp_result exp_target flags(take, flushed); kind 1 = hazard, kind F = end
01100000 00000000 00000000 00000000 00000005 00000007 01 0000000C 00000000 00
01110000 00000000 00000000 00000000 00000003 00000005 02 FFFFFFFE 00000000 00
01300000 00000000 00000000 00000000 FFFFFFFD 00000007 16 FFFFFFEB 00000000 00
01301000 00000000 00000000 00000000 FFFFFFFD 00000007 17 FFFFFFFF 00000000 00
01302000 00000000 00000000 00000000 FFFFFFFF FFFFFFFF 18 FFFFFFFF 00000000 00
01303000 00000000 00000000 00000000 FFFFFFFF FFFFFFFF 19 FFFFFFFE 00000000 00
01300000 00000000 00000000 00000000 12345678 00010000 1A 56780000 00000000 00
01301000 00000000 00000000 00000000 40000000 40000000 1B 10000000 00000000 00
01302000 00000000 00000000 00000000 00000002 80000000 1C 00000001 00000000 00
01303000 00000000 00000000 00000000 80000000 00000004 1D 00000002 00000000 00
01120000 00000000 00000000 00000000 F0F0F0F0 0FF00FF0 03 00F000F0 00000000 00
01130000 00000000 00000000 00000000 F0F0F0F0 0FF00FF0 04 FFF0FFF0 00000000 00
01140000 00000000 00000000 00000000 F0F0F0F0 0FF00FF0 05 FF00FF00 00000000 00
01150000 00000000 00000000 00000000 FFFFFFFE 00000001 06 00000001 00000000 00
01160000 00000000 00000000 00000000 FFFFFFFE 00000001 07 00000000 00000000 00
01170000 00000000 00000000 00000000 00000003 00000024 08 00000030 00000000 00
01180000 00000000 00000000 00000000 80000000 00000004 09 08000000 00000000 00
01190000 00000000 00000000 00000000 80000000 00000004 0A F8000000 00000000 00
01100010 FFF00093 00000000 00000000 00000010 00000000 0B 0000000F 00000000 00
01100020 7E000C23 00000000 00000000 00001000 00000000 0C 000017F8 00000000 00
01100340 12345037 00000000 00000000 00000000 00000000 0D 12345000 00000000 00
01100240 FFFFF017 00002000 00000000 00000000 00000000 0E 00001000 00000000 00
01200032 00000863 00000100 00000000 00000005 00000005 0F 00000000 00000110 10
01200032 FE001CE3 00000200 00000000 00000005 00000005 10 00000000 000001F8 00
01200032 00004863 00000300 00000000 FFFFFFFF 00000001 11 00000000 00000310 10
01200032 00005863 00000400 00000000 FFFFFFFF 00000001 12 00000000 00000410 00
01200032 00006863 00000500 00000000 FFFFFFFF 00000001 13 00000000 00000510 00
01200032 00007863 00000600 00000000 FFFFFFFF 00000001 14 00000000 00000610 10
01100251 0200006F 00000700 00000704 00000000 00000000 15 00000704 00000720 10
01100011 00400067 00000800 00000804 00001000 00000000 00 00000804 00001004 10
01300000 00000000 00000000 00000000 00000003 00000003 1E 00000009 00000000 01
01303000 00000000 00000000 00000000 00000003 00000003 1F 00000000 00000000 01
10000000 00000000 00000000 00000000 00000000 00000000 00 00000000 00000000 00
01300000 00000000 00000000 00000000 00000006 00000007 20 0000002A 00000000 00
01100000 00000000 00000000 00000000 00000001 00000002 21 00000003 00000000 00
F0000000 00000000 00000000 00000000 00000000 00000000 00 00000000 00000000 00

/* sim/ex_stage_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "ex_consts.svh"

module ex_stage_tb;

	localparam int NW     = `EX_N_WAY;
	localparam int ROW_W  = 10;   // words per slot line
	localparam int MEM_W  = 1024;
	localparam int N_TAGS = 1 << `EX_CDB_BITS;

	logic clock = 1'b0;
	logic reset;
	logic branch_haz;
	logic [NW-1:0]                      issue_valid, issue_cond_br, issue_uncond_br;
	ex_pkg::ex_unit_e   [NW-1:0]        issue_unit;
	ex_pkg::alu_func_e  [NW-1:0]        issue_alu_func;
	ex_pkg::mult_func_e [NW-1:0]        issue_mult_func;
	ex_pkg::opa_sel_e   [NW-1:0]        issue_opa_sel;
	ex_pkg::opb_sel_e   [NW-1:0]        issue_opb_sel;
	ex_pkg::word_t      [NW-1:0]        issue_inst, issue_pc, issue_npc, issue_rs1, issue_rs2;
	ex_pkg::tag_t       [NW-1:0]        issue_tag;
	logic [NW-1:0]                      complete_valid, reg_wr_en, take_branch;
	ex_pkg::tag_t       [NW-1:0]        complete_tag;
	ex_pkg::word_t      [NW-1:0]        ex_result, br_target;

	logic [31:0]   pat [MEM_W];
	logic          exp_known [N_TAGS];
	logic          exp_flush [N_TAGS];
	logic          exp_mult  [N_TAGS];
	logic          exp_br    [N_TAGS];
	logic          exp_take  [N_TAGS];
	logic          exp_wr    [N_TAGS];
	ex_pkg::word_t exp_result [N_TAGS];
	ex_pkg::word_t exp_target [N_TAGS];
	int            issue_cycle [N_TAGS];
	int            seen [N_TAGS];
	ex_pkg::tag_t  int_order [$]; // integer results leave in issue order
	int            cycle = 0;
	int            outstanding = 0;
	int            n_rows = 0;

	ex_stage u_ex_stage (.*);

	always #5 clock = ~clock;

	always @(posedge clock) cycle <= cycle + 1;

	task automatic report_failure(input string msg);
		$display("%s", msg);
		$display("TEST RESULT: FAIL");
		$fatal(1, "stopping at first error");
	endtask

	task automatic check_word(input string name, input ex_pkg::word_t got,
		input ex_pkg::word_t exp);
		if (got !== exp)
			report_failure($sformatf("Fail at %0t: %s got %h expected %h",
				$time, name, got, exp));
	endtask

	task automatic check_tag(input string name, input ex_pkg::tag_t got,
		input ex_pkg::tag_t exp);
		if (got !== exp)
			report_failure($sformatf("Fail at %0t: %s got %0d expected %0d",
				$time, name, got, exp));
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		if (got !== exp)
			report_failure($sformatf("Fail at %0t: %s got %b expected %b",
				$time, name, got, exp));
	endtask

	task automatic clear_inputs();
		branch_haz = 1'b0;
		for (int w = 0; w < NW; w++) begin
			issue_valid[w]     = 1'b0;
			issue_cond_br[w]   = 1'b0;
			issue_uncond_br[w] = 1'b0;
			issue_unit[w]      = ex_pkg::UNIT_NONE;
			issue_alu_func[w]  = ex_pkg::ALU_ADD;
			issue_mult_func[w] = ex_pkg::MUL;
			issue_opa_sel[w]   = ex_pkg::OPA_IS_RS1;
			issue_opb_sel[w]   = ex_pkg::OPB_IS_RS2;
			issue_inst[w]      = '0;
			issue_pc[w]        = '0;
			issue_npc[w]       = '0;
			issue_rs1[w]       = '0;
			issue_rs2[w]       = '0;
			issue_tag[w]       = '0;
		end
	endtask

	// one slot line onto way w, and its expectation into the tag table
	task automatic drive_slot(input int w, input int base);
		logic [31:0]  ctl;
		ex_pkg::tag_t t;
		ctl = pat[base];
		t   = ex_pkg::tag_t'(pat[base+6]);
		issue_valid[w]     = ctl[24];
		issue_unit[w]      = ex_pkg::ex_unit_e'(ctl[21:20]);
		issue_alu_func[w]  = ex_pkg::alu_func_e'(ctl[19:16]);
		issue_mult_func[w] = ex_pkg::mult_func_e'(ctl[13:12]);
		if (ctl[21:20] == 2'd2)
			issue_opa_sel[w] = ex_pkg::OPA_IS_PC; // branch targets are pc relative
		else
			issue_opa_sel[w] = ex_pkg::opa_sel_e'(ctl[9:8]);
		issue_opb_sel[w]   = ex_pkg::opb_sel_e'(ctl[6:4]);
		issue_cond_br[w]   = ctl[1];
		issue_uncond_br[w] = ctl[0];
		issue_inst[w]      = pat[base+1];
		issue_pc[w]        = pat[base+2];
		issue_npc[w]       = pat[base+3];
		issue_rs1[w]       = pat[base+4];
		issue_rs2[w]       = pat[base+5];
		issue_tag[w]       = t;
		if (ctl[24]) begin
			exp_known[t]   = 1'b1;
			exp_result[t]  = pat[base+7];
			exp_target[t]  = pat[base+8];
			exp_take[t]    = pat[base+9][4];
			exp_flush[t]   = pat[base+9][0];
			exp_mult[t]    = ctl[21:20] == 2'd3;
			exp_br[t]      = ctl[21:20] == 2'd2 || ctl[0];
			exp_wr[t]      = t != 0 && ctl[21:20] != 2'd2; // conditional branches write nothing
			issue_cycle[t] = cycle;
			if (!pat[base+9][0])
				outstanding++;
			if (ctl[21:20] != 2'd3)
				int_order.push_back(t);
		end
	endtask

	task automatic wait_for_drain();
		while (outstanding != 0)
			@(negedge clock);
	endtask

	//////////////////////////////////////////////////
	// completion monitor
	//////////////////////////////////////////////////
	always @(negedge clock) begin
		ex_pkg::tag_t t;
		if (!reset) begin
			for (int w = 0; w < NW; w++) begin
				if (complete_valid[w]) begin
					t = complete_tag[w];
					if (!exp_known[t])
						report_failure($sformatf("tag %0d completed but was never issued", t));
					if (exp_flush[t])
						report_failure($sformatf("tag %0d completed after a branch hazard", t));
					if (seen[t] != 0)
						report_failure($sformatf("tag %0d completed more than once", t));
					check_word($sformatf("ex_result[%0d]", w), ex_result[w], exp_result[t]);
					check_bit($sformatf("take_branch[%0d]", w), take_branch[w], exp_take[t]);
					check_bit($sformatf("reg_wr_en[%0d]", w), reg_wr_en[w], exp_wr[t]);
					if (exp_br[t])
						check_word($sformatf("br_target[%0d]", w), br_target[w], exp_target[t]);
					if (exp_mult[t] && cycle - issue_cycle[t] < `EX_MULT_STAGES + 1)
						report_failure($sformatf("multiply tag %0d completed too early", t));
					if (!exp_mult[t])
						check_tag($sformatf("complete_tag[%0d]", w), t, int_order.pop_front());
					seen[t] = seen[t] + 1;
					outstanding--;
				end else begin
					check_bit($sformatf("reg_wr_en[%0d]", w), reg_wr_en[w], 1'b0);
				end
			end
		end
	end

	initial begin
		wait (n_rows > 0);
		#(n_rows * 10 * 20);
		report_failure("watchdog timeout, the run did not finish in time");
	end

	initial begin
		int unsigned seed_val;
		int          idx;
		int          missing;
		seed_val = $urandom(32'hf52e_8761);
		for (int t = 0; t < N_TAGS; t++) begin
			exp_known[t] = 1'b0;
			exp_flush[t] = 1'b0;
			seen[t]      = 0;
		end
		reset = 1'b1;
		clear_inputs();
		$readmemh("sim/ex_patterns.hex", pat);
		idx = 0;
		while (idx < MEM_W && pat[idx][31:28] != 4'hf) begin
			idx += (pat[idx][31:28] == 4'h1) ? ROW_W : 2 * ROW_W;
			n_rows++;
		end
		if (n_rows == 0)
			report_failure("the pattern file held no stimulus rows");
		repeat (4) @(negedge clock);
		reset = 1'b0;

		idx = 0;
		while (pat[idx][31:28] != 4'hf) begin
			// pending work must be out before a row that a hazard will flush
			if (pat[idx][31:28] == 4'h0 && (pat[idx+9][0] || pat[idx+ROW_W+9][0]))
				wait_for_drain();
			@(negedge clock);
			clear_inputs();
			if (pat[idx][31:28] == 4'h1) begin
				branch_haz = 1'b1;
				idx += ROW_W;
			end else begin
				drive_slot(0, idx);
				drive_slot(1, idx + ROW_W);
				idx += 2 * ROW_W;
			end
			repeat ($urandom_range(3, 0)) begin
				@(negedge clock);
				clear_inputs();
			end
		end
		@(negedge clock);
		clear_inputs();
		wait_for_drain();
		repeat (`EX_MULT_STAGES + 3) @(negedge clock); // room for late strays

		missing = 0;
		for (int t = 0; t < N_TAGS; t++) begin
			if (exp_known[t] && !exp_flush[t] && seen[t] != 1)
				missing++;
		end
		if (missing != 0) begin
			report_failure($sformatf("%0d issued tags did not complete exactly once", missing));
		end else begin
			$display("TEST RESULT: PASS");
			$finish;
		end
	end

endmodule

`default_nettype wire

/* design/ex_stage.sv */
`timescale 1ns/1ps
`default_nettype none

`include "ex_consts.svh"

module ex_stage (
	input  wire                                       clock,
	input  wire                                       reset,
	input  wire                                       branch_haz,
	input  wire  [`EX_N_WAY-1:0]                      issue_valid,
	input  wire  ex_pkg::ex_unit_e   [`EX_N_WAY-1:0]  issue_unit,
	input  wire  ex_pkg::alu_func_e  [`EX_N_WAY-1:0]  issue_alu_func,
	input  wire  ex_pkg::mult_func_e [`EX_N_WAY-1:0]  issue_mult_func,
	input  wire  ex_pkg::opa_sel_e   [`EX_N_WAY-1:0]  issue_opa_sel,
	input  wire  ex_pkg::opb_sel_e   [`EX_N_WAY-1:0]  issue_opb_sel,
	input  wire  ex_pkg::word_t      [`EX_N_WAY-1:0]  issue_inst,
	input  wire  ex_pkg::word_t      [`EX_N_WAY-1:0]  issue_pc,
	input  wire  ex_pkg::word_t      [`EX_N_WAY-1:0]  issue_npc,
	input  wire  ex_pkg::word_t      [`EX_N_WAY-1:0]  issue_rs1,
	input  wire  ex_pkg::word_t      [`EX_N_WAY-1:0]  issue_rs2,
	input  wire  ex_pkg::tag_t       [`EX_N_WAY-1:0]  issue_tag,
	input  wire  [`EX_N_WAY-1:0]                      issue_cond_br,
	input  wire  [`EX_N_WAY-1:0]                      issue_uncond_br,
	output logic [`EX_N_WAY-1:0]                      complete_valid,
	output ex_pkg::tag_t  [`EX_N_WAY-1:0]             complete_tag,
	output logic [`EX_N_WAY-1:0]                      reg_wr_en,
	output ex_pkg::word_t [`EX_N_WAY-1:0]             ex_result,
	output logic [`EX_N_WAY-1:0]                      take_branch,
	output ex_pkg::word_t [`EX_N_WAY-1:0]             br_target
);

	// router to integer lanes
	ex_pkg::word_t     [`EX_N_WAY-1:0] int_opa, int_opb, int_rs1, int_rs2;
	ex_pkg::alu_func_e [`EX_N_WAY-1:0] int_func;
	logic [`EX_N_WAY-1:0][2:0]         int_br_funct3;
	logic [`EX_N_WAY-1:0]              int_is_branch, int_cond_br, int_uncond_br, int_valid;
	ex_pkg::tag_t      [`EX_N_WAY-1:0] int_tag;

	// router to multiplier lanes
	logic [`EX_N_WAY-1:0]               mult_start;
	ex_pkg::word_t      [`EX_N_WAY-1:0] mult_mcand, mult_mplier;
	ex_pkg::mult_func_e [`EX_N_WAY-1:0] mult_func;
	ex_pkg::tag_t       [`EX_N_WAY-1:0] mult_tag;

	// lanes to completion queue
	ex_pkg::word_t [`EX_N_WAY-1:0] int_result, int_target, mult_product;
	logic [`EX_N_WAY-1:0]          int_take_branch, mult_done;
	ex_pkg::tag_t  [`EX_N_WAY-1:0] mult_done_tag;

	ex_issue_router u_router (.*);

	for (genvar w = 0; w < `EX_N_WAY; w++) begin : g_way
		ex_int_lane u_int_lane (
			.opa(int_opa[w]), .opb(int_opb[w]), .rs1(int_rs1[w]), .rs2(int_rs2[w]),
			.func(int_func[w]), .br_funct3(int_br_funct3[w]), .is_branch(int_is_branch[w]),
			.cond_br(int_cond_br[w]), .uncond_br(int_uncond_br[w]),
			.result(int_result[w]), .take_branch(int_take_branch[w]), .target(int_target[w])
		);

		ex_mult_lane u_mult_lane (
			.clock(clock), .reset(reset), .branch_haz(branch_haz),
			.start(mult_start[w]), .func(mult_func[w]), .tag(mult_tag[w]),
			.mcand(mult_mcand[w]), .mplier(mult_mplier[w]),
			.done(mult_done[w]), .done_tag(mult_done_tag[w]), .product(mult_product[w])
		);
	end

	ex_complete_queue u_cq (
		.clock(clock), .reset(reset), .branch_haz(branch_haz),
		.int_valid(int_valid), .int_tag(int_tag), .int_result(int_result),
		.int_take_branch(int_take_branch), .int_target(int_target),
		.int_is_branch(int_is_branch),
		.mult_done(mult_done), .mult_tag(mult_done_tag), .mult_product(mult_product),
		.complete_valid(complete_valid), .complete_tag(complete_tag), .reg_wr_en(reg_wr_en),
		.ex_result(ex_result), .take_branch(take_branch), .br_target(br_target)
	);

endmodule

`default_nettype wire

/* design/ex_complete_queue.sv */
`timescale 1ns/1ps
`default_nettype none

`include "ex_consts.svh"

module ex_complete_queue (
	input  wire                                 clock,
	input  wire                                 reset,
	input  wire                                 branch_haz,
	input  wire [`EX_N_WAY-1:0]                 int_valid,
	input  wire ex_pkg::tag_t  [`EX_N_WAY-1:0]  int_tag,
	input  wire ex_pkg::word_t [`EX_N_WAY-1:0]  int_result,
	input  wire [`EX_N_WAY-1:0]                 int_take_branch,
	input  wire ex_pkg::word_t [`EX_N_WAY-1:0]  int_target,
	input  wire [`EX_N_WAY-1:0]                 int_is_branch,
	input  wire [`EX_N_WAY-1:0]                 mult_done,
	input  wire ex_pkg::tag_t  [`EX_N_WAY-1:0]  mult_tag,
	input  wire ex_pkg::word_t [`EX_N_WAY-1:0]  mult_product,
	output logic [`EX_N_WAY-1:0]                complete_valid,
	output ex_pkg::tag_t  [`EX_N_WAY-1:0]       complete_tag,
	output logic [`EX_N_WAY-1:0]                reg_wr_en,
	output ex_pkg::word_t [`EX_N_WAY-1:0]       ex_result,
	output logic [`EX_N_WAY-1:0]                take_branch,
	output ex_pkg::word_t [`EX_N_WAY-1:0]       br_target
);

	localparam int NW   = `EX_N_WAY;
	localparam int N_IN = 2 * `EX_N_WAY; // mult lanes then int lanes
	localparam int PW   = $clog2(`EX_CQ_DEPTH);

	ex_pkg::cq_entry_t [N_IN-1:0]         in_entry;
	logic [N_IN-1:0]                      in_cbr;
	logic [N_IN-1:0][PW-1:0]              wr_idx;
	logic [PW:0]                          n_in;
	logic [PW:0]                          n_out;
	logic [PW-1:0]                        head;
	logic [PW-1:0]                        tail;
	logic [PW:0]                          count;
	ex_pkg::cq_entry_t                    q [`EX_CQ_DEPTH];
	logic [`EX_CQ_DEPTH-1:0]              cbr_q; // conditional branch, no write

	always_comb begin
		for (int w = 0; w < NW; w++) begin
			in_entry[w]    = '{valid: mult_done[w], tag: mult_tag[w], result: mult_product[w],
				take_branch: 1'b0, br_target: '0};
			in_cbr[w]      = 1'b0;
			in_entry[NW+w] = '{valid: int_valid[w], tag: int_tag[w], result: int_result[w],
				take_branch: int_take_branch[w], br_target: int_target[w]};
			in_cbr[NW+w]   = int_is_branch[w];
		end
	end

	// pack strobed results behind tail
	always_comb begin
		n_in = '0;
		for (int k = 0; k < N_IN; k++) begin
			wr_idx[k] = PW'(tail + n_in);
			if (in_entry[k].valid)
				n_in = n_in + 1'b1;
		end
	end

	assign n_out = (count > NW) ? (PW+1)'(NW) : count; // up to two leave per edge

	always_ff @(posedge clock) begin
		if (reset || branch_haz) begin
			head  <= '0;
			tail  <= '0;
			count <= '0;
		end else begin
			head  <= PW'(head + n_out);
			tail  <= PW'(tail + n_in);
			count <= count + n_in - n_out;
		end
	end

	always_ff @(posedge clock) begin
		for (int k = 0; k < N_IN; k++) begin
			if (in_entry[k].valid) begin
				q[wr_idx[k]]     <= in_entry[k];
				cbr_q[wr_idx[k]] <= in_cbr[k];
			end
		end
	end

	////////////////////////////////////////////////////
	// oldest entries out
	////////////////////////////////////////////////////
	always_comb begin
		logic [PW-1:0] rd_idx;
		for (int w = 0; w < NW; w++) begin
			rd_idx            = PW'(head + w);
			complete_valid[w] = count > w;
			complete_tag[w]   = q[rd_idx].tag;
			ex_result[w]      = q[rd_idx].result;
			take_branch[w]    = complete_valid[w] & q[rd_idx].take_branch;
			br_target[w]      = q[rd_idx].br_target;
			reg_wr_en[w]      = complete_valid[w] && !cbr_q[rd_idx] &&
				q[rd_idx].tag != ex_pkg::tag_t'(`EX_ZERO_TAG);
		end
	end

	// no back-pressure upstream, so the stimulus must leave room
	a_no_overflow: assert property (@(posedge clock) disable iff (reset)
		!branch_haz |-> (count + n_in - n_out <= `EX_CQ_DEPTH));

endmodule

`default_nettype wire

/* design/ex_mult_lane.sv */
`timescale 1ns/1ps
`default_nettype none

`include "ex_consts.svh"

module ex_mult_lane (
	input  wire                     clock,
	input  wire                     reset,
	input  wire                     branch_haz,
	input  wire                     start,
	input  wire ex_pkg::mult_func_e func,
	input  wire ex_pkg::tag_t       tag,
	input  wire ex_pkg::word_t      mcand,
	input  wire ex_pkg::word_t      mplier,
	output logic                    done,
	output ex_pkg::tag_t            done_tag,
	output ex_pkg::word_t           product
);

	localparam int XL = `EX_XLEN;
	localparam int DW = 2 * `EX_XLEN;
	localparam int S  = `EX_MULT_STAGES;
	localparam int MB = `EX_MULT_BITS;

	logic               mcand_sgn;
	logic               mplier_sgn;
	logic               vld_q    [S+1];
	logic [DW-1:0]      prod_q   [S+1];
	logic [DW-1:0]      mcand_q  [S+1];
	logic [DW-1:0]      mplier_q [S+1];
	ex_pkg::mult_func_e func_q   [S+1];
	ex_pkg::tag_t       tag_q    [S+1];

	// mulhsu has a signed mcand and an unsigned mplier
	assign mcand_sgn  = func != ex_pkg::MULHU;
	assign mplier_sgn = func == ex_pkg::MUL || func == ex_pkg::MULH;

	assign vld_q[0]    = start;
	assign prod_q[0]   = '0;
	assign mcand_q[0]  = {{XL{mcand_sgn & mcand[XL-1]}}, mcand};
	assign mplier_q[0] = {{XL{mplier_sgn & mplier[XL-1]}}, mplier};
	assign func_q[0]   = func;
	assign tag_q[0]    = tag;

	////////////////////////////////////////////////////
	// stages
	////////////////////////////////////////////////////
	for (genvar i = 0; i < S; i++) begin : g_stage
		always_ff @(posedge clock) begin
			if (reset || branch_haz)
				vld_q[i+1] <= 1'b0;
			else
				vld_q[i+1] <= vld_q[i];
		end

		// one MB-bit slice of the mplier per stage
		always_ff @(posedge clock) begin
			prod_q[i+1]   <= prod_q[i] + mcand_q[i] * DW'(mplier_q[i][MB-1:0]);
			mcand_q[i+1]  <= mcand_q[i] << MB;
			mplier_q[i+1] <= mplier_q[i] >> MB;
			func_q[i+1]   <= func_q[i];
			tag_q[i+1]    <= tag_q[i];
		end
	end

	assign done     = vld_q[S];
	assign done_tag = tag_q[S];
	assign product  = (func_q[S] == ex_pkg::MUL) ? prod_q[S][XL-1:0] : prod_q[S][DW-1:XL];

	a_func_known: assert property (@(posedge clock) disable iff (reset)
		start |-> !$isunknown(func));

endmodule

`default_nettype wire

/* design/ex_int_lane.sv */
`timescale 1ns/1ps
`default_nettype none

`include "ex_consts.svh"

module ex_int_lane (
	input  wire ex_pkg::word_t     opa,
	input  wire ex_pkg::word_t     opb,
	input  wire ex_pkg::word_t     rs1,
	input  wire ex_pkg::word_t     rs2,
	input  wire ex_pkg::alu_func_e func,
	input  wire [2:0]              br_funct3,
	input  wire                    is_branch,
	input  wire                    cond_br,
	input  wire                    uncond_br,
	output ex_pkg::word_t          result,
	output logic                   take_branch,
	output ex_pkg::word_t          target
);

	localparam int SHW = $clog2(`EX_XLEN);

	ex_pkg::word_t sum;
	ex_pkg::word_t alu_out;
	logic          cond;

	assign sum = opa + opb; // shared by add, branch and jump targets

	always_comb begin
		case (func)
			ex_pkg::ALU_ADD:  alu_out = sum;
			ex_pkg::ALU_SUB:  alu_out = opa - opb;
			ex_pkg::ALU_AND:  alu_out = opa & opb;
			ex_pkg::ALU_OR:   alu_out = opa | opb;
			ex_pkg::ALU_XOR:  alu_out = opa ^ opb;
			ex_pkg::ALU_SLT:  alu_out = {{(`EX_XLEN-1){1'b0}}, $signed(opa) < $signed(opb)};
			ex_pkg::ALU_SLTU: alu_out = {{(`EX_XLEN-1){1'b0}}, opa < opb};
			ex_pkg::ALU_SLL:  alu_out = opa << opb[SHW-1:0];
			ex_pkg::ALU_SRL:  alu_out = opa >> opb[SHW-1:0];
			ex_pkg::ALU_SRA:  alu_out = ex_pkg::word_t'($signed(opa) >>> opb[SHW-1:0]);
			default:          alu_out = 32'hface_beec;
		endcase
	end

	// branch compare on funct3
	always_comb begin
		case (br_funct3)
			3'b000:  cond = rs1 == rs2;                   // beq
			3'b001:  cond = rs1 != rs2;                   // bne
			3'b100:  cond = $signed(rs1) < $signed(rs2);  // blt
			3'b101:  cond = $signed(rs1) >= $signed(rs2); // bge
			3'b110:  cond = rs1 < rs2;                    // bltu
			3'b111:  cond = rs1 >= rs2;                   // bgeu
			default: cond = 1'b0;
		endcase
	end

	assign take_branch = uncond_br | (is_branch & cond_br & cond);
	assign target      = sum;

	// branches write nothing, jumps write the link
	assign result = is_branch ? '0 : (uncond_br ? rs1 + rs2 : alu_out);

endmodule

`default_nettype wire

/* design/ex_issue_router.sv */
`timescale 1ns/1ps
`default_nettype none

`include "ex_consts.svh"

module ex_issue_router (
	input  wire  [`EX_N_WAY-1:0]                     issue_valid,
	input  wire  ex_pkg::ex_unit_e   [`EX_N_WAY-1:0] issue_unit,
	input  wire  ex_pkg::alu_func_e  [`EX_N_WAY-1:0] issue_alu_func,
	input  wire  ex_pkg::mult_func_e [`EX_N_WAY-1:0] issue_mult_func,
	input  wire  ex_pkg::opa_sel_e   [`EX_N_WAY-1:0] issue_opa_sel,
	input  wire  ex_pkg::opb_sel_e   [`EX_N_WAY-1:0] issue_opb_sel,
	input  wire  ex_pkg::word_t      [`EX_N_WAY-1:0] issue_inst,
	input  wire  ex_pkg::word_t      [`EX_N_WAY-1:0] issue_pc,
	input  wire  ex_pkg::word_t      [`EX_N_WAY-1:0] issue_npc,
	input  wire  ex_pkg::word_t      [`EX_N_WAY-1:0] issue_rs1,
	input  wire  ex_pkg::word_t      [`EX_N_WAY-1:0] issue_rs2,
	input  wire  ex_pkg::tag_t       [`EX_N_WAY-1:0] issue_tag,
	input  wire  [`EX_N_WAY-1:0]                     issue_cond_br,
	input  wire  [`EX_N_WAY-1:0]                     issue_uncond_br,
	output ex_pkg::word_t      [`EX_N_WAY-1:0]       int_opa,
	output ex_pkg::word_t      [`EX_N_WAY-1:0]       int_opb,
	output ex_pkg::word_t      [`EX_N_WAY-1:0]       int_rs1,
	output ex_pkg::word_t      [`EX_N_WAY-1:0]       int_rs2,
	output ex_pkg::alu_func_e  [`EX_N_WAY-1:0]       int_func,
	output logic [`EX_N_WAY-1:0][2:0]                int_br_funct3,
	output logic [`EX_N_WAY-1:0]                     int_is_branch,
	output logic [`EX_N_WAY-1:0]                     int_cond_br,
	output logic [`EX_N_WAY-1:0]                     int_uncond_br,
	output logic [`EX_N_WAY-1:0]                     int_valid,
	output ex_pkg::tag_t       [`EX_N_WAY-1:0]       int_tag,
	output logic [`EX_N_WAY-1:0]                     mult_start,
	output ex_pkg::word_t      [`EX_N_WAY-1:0]       mult_mcand,
	output ex_pkg::word_t      [`EX_N_WAY-1:0]       mult_mplier,
	output ex_pkg::mult_func_e [`EX_N_WAY-1:0]       mult_func,
	output ex_pkg::tag_t       [`EX_N_WAY-1:0]       mult_tag
);

	localparam ex_pkg::word_t OPA_MARK = 32'hdead_fbac; // bad opa select
	localparam ex_pkg::word_t OPB_MARK = 32'hface_feed; // bad opb select

	always_comb begin
		ex_pkg::word_t inst;
		ex_pkg::word_t imm_i, imm_s, imm_b, imm_u, imm_j;
		for (int w = 0; w < `EX_N_WAY; w++) begin
			inst  = issue_inst[w];
			imm_i = {{20{inst[31]}}, inst[31:20]};
			imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
			imm_b = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
			imm_u = {inst[31:12], 12'b0};
			imm_j = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

			case (issue_opa_sel[w])
				ex_pkg::OPA_IS_RS1:  int_opa[w] = issue_rs1[w];
				ex_pkg::OPA_IS_NPC:  int_opa[w] = issue_npc[w];
				ex_pkg::OPA_IS_PC:   int_opa[w] = issue_pc[w];
				ex_pkg::OPA_IS_ZERO: int_opa[w] = '0;
				default:             int_opa[w] = OPA_MARK;
			endcase
			case (issue_opb_sel[w])
				ex_pkg::OPB_IS_RS2:   int_opb[w] = issue_rs2[w];
				ex_pkg::OPB_IS_I_IMM: int_opb[w] = imm_i;
				ex_pkg::OPB_IS_S_IMM: int_opb[w] = imm_s;
				ex_pkg::OPB_IS_B_IMM: int_opb[w] = imm_b;
				ex_pkg::OPB_IS_U_IMM: int_opb[w] = imm_u;
				ex_pkg::OPB_IS_J_IMM: int_opb[w] = imm_j;
				default:              int_opb[w] = OPB_MARK;
			endcase

			// jumps link through the lane's second adder, npc + 0
			int_rs1[w] = issue_uncond_br[w] ? issue_npc[w] : issue_rs1[w];
			int_rs2[w] = issue_uncond_br[w] ? '0 : issue_rs2[w];

			int_valid[w]     = issue_valid[w] && (issue_unit[w] == ex_pkg::UNIT_ALU ||
				issue_unit[w] == ex_pkg::UNIT_BRANCH);
			int_is_branch[w] = issue_valid[w] && issue_unit[w] == ex_pkg::UNIT_BRANCH;
			int_cond_br[w]   = issue_cond_br[w];
			int_uncond_br[w] = issue_uncond_br[w];
			int_func[w]      = issue_alu_func[w];
			int_br_funct3[w] = inst[14:12];
			int_tag[w]       = issue_tag[w];

			mult_start[w]  = issue_valid[w] && issue_unit[w] == ex_pkg::UNIT_MULT;
			mult_mcand[w]  = issue_rs1[w];
			mult_mplier[w] = issue_rs2[w];
			mult_func[w]   = issue_mult_func[w];
			mult_tag[w]    = issue_tag[w];
		end
	end

endmodule

`default_nettype wire

/* design/ex_pkg.sv */
`default_nettype none

`include "ex_consts.svh"

package ex_pkg;

	typedef logic [`EX_XLEN-1:0]     word_t;
	typedef logic [`EX_CDB_BITS-1:0] tag_t;

	typedef enum logic [1:0] {
		UNIT_NONE,
		UNIT_ALU,
		UNIT_BRANCH,
		UNIT_MULT
	} ex_unit_e;

	typedef enum logic [3:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_XOR,
		ALU_SLT,
		ALU_SLTU,
		ALU_SLL,
		ALU_SRL,
		ALU_SRA
	} alu_func_e;

	typedef enum logic [1:0] {MUL, MULH, MULHSU, MULHU} mult_func_e;

	typedef enum logic [1:0] {OPA_IS_RS1, OPA_IS_NPC, OPA_IS_PC, OPA_IS_ZERO} opa_sel_e;

	typedef enum logic [2:0] {
		OPB_IS_RS2,
		OPB_IS_I_IMM,
		OPB_IS_S_IMM,
		OPB_IS_B_IMM,
		OPB_IS_U_IMM,
		OPB_IS_J_IMM
	} opb_sel_e;

	// one completion queue slot
	typedef struct packed {
		logic  valid;
		tag_t  tag;
		word_t result;
		logic  take_branch;
		word_t br_target;
	} cq_entry_t;

endpackage

`default_nettype wire

/* include/ex_consts.svh */
`ifndef EX_CONSTS_SVH
`define EX_CONSTS_SVH

////////////////////////////////////////////////////
// datapath
////////////////////////////////////////////////////
`define EX_XLEN         32
`define EX_N_WAY        2   // issue and completion slots
`define EX_CDB_BITS     6
`define EX_ZERO_TAG     0   // tag that writes nothing

////////////////////////////////////////////////////
// multiplier and completion queue
////////////////////////////////////////////////////
`define EX_MULT_STAGES  4
`define EX_MULT_BITS    16  // 2*XLEN over the stage count
`define EX_CQ_DEPTH     16  // power of two, pointers wrap

`endif
